//--- hw/mipsPkg.sv
// widths and field types of the integer core
// opcode, funct and mux select constants
// ALU and control FSM enums, instruction and control structs
`default_nettype none

package mipsPkg;

	typedef logic [31:0] word_t;     // data or address word
	typedef logic [4:0]  regAddr_t;  // register index
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;

	localparam int    regCount = 32;
	localparam word_t pcStep   = 32'd4;  // one word ahead

	// supported opcodes
	localparam opcode_t opRType = 6'h00;
	localparam opcode_t opJ     = 6'h02;
	localparam opcode_t opBeq   = 6'h04;
	localparam opcode_t opBne   = 6'h05;
	localparam opcode_t opAddi  = 6'h08;
	localparam opcode_t opLw    = 6'h23;
	localparam opcode_t opSw    = 6'h2b;

	// R-type funct codes
	localparam funct_t fnAdd = 6'h20;
	localparam funct_t fnSub = 6'h22;
	localparam funct_t fnAnd = 6'h24;
	localparam funct_t fnOr  = 6'h25;
	localparam funct_t fnSlt = 6'h2a;

	// mux selects
	localparam logic       srcAPc      = 1'b0;   // ALU A from PC
	localparam logic       srcAReg     = 1'b1;   // ALU A from A register
	localparam logic [1:0] srcBReg     = 2'd0;
	localparam logic [1:0] srcBStep    = 2'd1;
	localparam logic [1:0] srcBImm     = 2'd2;
	localparam logic [1:0] srcBBranch  = 2'd3;   // imm << 2
	localparam logic [1:0] pcSrcAlu    = 2'd0;
	localparam logic [1:0] pcSrcAluOut = 2'd1;
	localparam logic [1:0] pcSrcJump   = 2'd2;

	typedef enum logic [1:0] {aluOpAdd, aluOpSub, aluOpFunct} aluOp_t;

	typedef enum logic [2:0] {selAnd, selOr, selAdd, selSub, selSlt} aluSel_t;

	typedef enum logic [3:0] {
		stFetch, stDecode,
		stMemAddr, stMemRead, stMemWriteback, stMemWrite,
		stExecute, stRWriteback,
		stAddiExec, stAddiWriteback,
		stBranch, stJump
	} ctrlState_t;

	// overlay of the instruction word, msb first
	typedef struct packed {
		opcode_t    opcode;
		regAddr_t   rs;
		regAddr_t   rt;
		regAddr_t   rd;
		logic [4:0] shamt;
		funct_t     funct;
	} instrFields_t;

	typedef struct packed {
		logic       irWrite;
		logic       iorD;        // 0 PC, 1 ALUOut on the bus
		logic       memRead;
		logic       memWrite;
		logic       memToReg;
		logic       pcWrite;
		logic       pcWriteBeq;
		logic       pcWriteBne;
		logic       regWrite;
		logic       regDst;      // 0 rt, 1 rd
		logic       aluSrcA;
		logic [1:0] aluSrcB;
		logic [1:0] pcSource;
		aluOp_t     aluOp;
	} ctrlSignals_t;

endpackage

`default_nettype wire

//--- hw/registerFile.sv
// general register bank, 32 x 32
// two async read ports, one sync write port, r0 reads as zero
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import mipsPkg::*;
(
	input  logic     iCLK,
	input  logic     iRST,
	input  regAddr_t readAddr1,
	input  regAddr_t readAddr2,
	input  regAddr_t writeAddr,
	input  word_t    writeData,
	input  logic     writeEnable,
	output word_t    readData1,
	output word_t    readData2
);

	word_t regs [regCount];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && (writeAddr != '0))  // r0 never written
			regs[writeAddr] <= writeData;
	end

	// read ports, no bypass of a same-cycle write
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

//--- hw/aluUnit.sv
// ALU control decode from aluOp and funct
// integer ALU with zero flag, purely combinational
`timescale 1ns/1ps
`default_nettype none

module aluUnit
	import mipsPkg::*;
(
	input  aluOp_t aluOp,
	input  funct_t funct,
	input  word_t  opA,
	input  word_t  opB,
	output word_t  result,
	output logic   zero
);

	aluSel_t aluSel;

	// operation select
	always_comb
	begin
		aluSel = selAdd;
		unique case (aluOp)
			aluOpAdd: aluSel = selAdd;  // address and PC math
			aluOpSub: aluSel = selSub;  // branch compare
			aluOpFunct:
			begin
				case (funct)
					fnAdd:   aluSel = selAdd;
					fnSub:   aluSel = selSub;
					fnAnd:   aluSel = selAnd;
					fnOr:    aluSel = selOr;
					fnSlt:   aluSel = selSlt;
					default: aluSel = selAdd;  // unknown funct falls back to add
				endcase
			end
			default: aluSel = selAdd;
		endcase
	end

	// datapath of the ALU
	always_comb
	begin
		result = '0;
		unique case (aluSel)
			selAnd: result = opA & opB;
			selOr:  result = opA | opB;
			selAdd: result = opA + opB;     // wraps, no overflow trap
			selSub: result = opA - opB;
			selSlt:
				result = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
			default: result = opA + opB;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hw/multiCycleControl.sv
// multicycle control FSM
// state register, opcode dispatch from decode, Moore output decode
`timescale 1ns/1ps
`default_nettype none

module multiCycleControl
	import mipsPkg::*;
(
	input  logic         iCLK,
	input  logic         iRST,
	input  opcode_t      opcode,
	output ctrlSignals_t ctrl,
	output ctrlState_t   state
);

	ctrlState_t nextState;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= stFetch;  // first fetch right after reset drops
		else
			state <= nextState;
	end

	// next state, one dispatch point in decode
	always_comb
	begin
		nextState = stFetch;
		unique case (state)
			stFetch:
				nextState = stDecode;
			stDecode:
			begin
				case (opcode)
					opLw, opSw: nextState = stMemAddr;
					opRType:    nextState = stExecute;
					opAddi:     nextState = stAddiExec;
					opBeq, opBne: nextState = stBranch;
					opJ:        nextState = stJump;
					default:    nextState = stFetch;  // unknown op acts as nop
				endcase
			end
			stMemAddr:
				nextState = (opcode == opLw) ? stMemRead : stMemWrite;
			stMemRead:       nextState = stMemWriteback;
			stMemWriteback:  nextState = stFetch;
			stMemWrite:      nextState = stFetch;
			stExecute:       nextState = stRWriteback;
			stRWriteback:    nextState = stFetch;
			stAddiExec:      nextState = stAddiWriteback;
			stAddiWriteback: nextState = stFetch;
			stBranch:        nextState = stFetch;
			stJump:          nextState = stFetch;
			default:         nextState = stFetch;
		endcase
	end

	// outputs per state, everything idle unless named
	always_comb
	begin
		ctrl = '0;
		unique case (state)
			stFetch:
			begin
				ctrl.memRead  = 1'b1;       // bus address is PC
				ctrl.irWrite  = 1'b1;
				ctrl.aluSrcA  = srcAPc;
				ctrl.aluSrcB  = srcBStep;
				ctrl.aluOp    = aluOpAdd;
				ctrl.pcSource = pcSrcAlu;   // PC + 4 straight from the ALU
				ctrl.pcWrite  = 1'b1;
			end
			stDecode:
			begin
				// branch target into ALUOut while A and B load
				ctrl.aluSrcA = srcAPc;
				ctrl.aluSrcB = srcBBranch;
				ctrl.aluOp   = aluOpAdd;
			end
			stMemAddr, stAddiExec:
			begin
				ctrl.aluSrcA = srcAReg;     // rs + sign-extended imm
				ctrl.aluSrcB = srcBImm;
				ctrl.aluOp   = aluOpAdd;
			end
			stMemRead:
			begin
				ctrl.memRead = 1'b1;
				ctrl.iorD    = 1'b1;
			end
			stMemWriteback:
			begin
				ctrl.regWrite = 1'b1;       // rt <= MDR
				ctrl.memToReg = 1'b1;
			end
			stMemWrite:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.iorD     = 1'b1;
			end
			stExecute:
			begin
				ctrl.aluSrcA = srcAReg;
				ctrl.aluSrcB = srcBReg;
				ctrl.aluOp   = aluOpFunct;
			end
			stRWriteback:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;       // rd target
			end
			stAddiWriteback:
				ctrl.regWrite = 1'b1;       // rt <= ALUOut
			stBranch:
			begin
				ctrl.aluSrcA    = srcAReg;
				ctrl.aluSrcB    = srcBReg;
				ctrl.aluOp      = aluOpSub;  // zero flag compares rs, rt
				ctrl.pcSource   = pcSrcAluOut;
				ctrl.pcWriteBeq = (opcode == opBeq);  // IR is stable here
				ctrl.pcWriteBne = (opcode == opBne);
			end
			stJump:
			begin
				ctrl.pcSource = pcSrcJump;
				ctrl.pcWrite  = 1'b1;
			end
			default:
				ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/datapathMulti.sv
// multicycle datapath top
// PC, IR, MDR, A, B and ALUOut with their source muxes
// control FSM, register bank and ALU instances, word memory bus
`timescale 1ns/1ps
`default_nettype none

module datapathMulti
	import mipsPkg::*;
(
	input  logic       iCLK,
	input  logic       iRST,
	input  word_t      iInitialPC,
	input  word_t      DwReadData,
	output word_t      DwAddress,
	output word_t      DwWriteData,
	output logic       DwReadEnable,
	output logic       DwWriteEnable,
	output word_t      oPC,
	output ctrlState_t oState
);

	// architectural and holding registers
	word_t pc;
	word_t ir;
	word_t mdr;
	word_t regA;
	word_t regB;
	word_t aluOut;

	instrFields_t instr;
	ctrlSignals_t ctrl;
	ctrlState_t   state;

	word_t    readData1;
	word_t    readData2;
	word_t    aluA;
	word_t    aluB;
	word_t    aluResult;
	word_t    pcNext;
	word_t    regWriteData;
	word_t    immExt;
	word_t    branchOff;
	word_t    jumpTarget;
	regAddr_t writeReg;
	logic     aluZero;
	logic     pcLoad;

	assign instr      = instrFields_t'(ir);
	assign immExt     = {{16{ir[15]}}, ir[15:0]};
	assign branchOff  = {{14{ir[15]}}, ir[15:0], 2'b00};  // word offset
	assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};     // pc already stepped

	// ALU sources
	assign aluA = (ctrl.aluSrcA == srcAReg) ? regA : pc;
	always_comb
	begin
		unique case (ctrl.aluSrcB)
			srcBReg:    aluB = regB;
			srcBStep:   aluB = pcStep;
			srcBImm:    aluB = immExt;
			srcBBranch: aluB = branchOff;
			default:    aluB = regB;
		endcase
	end

	// next PC source
	always_comb
	begin
		unique case (ctrl.pcSource)
			pcSrcAlu:    pcNext = aluResult;
			pcSrcAluOut: pcNext = aluOut;     // branch target from decode
			pcSrcJump:   pcNext = jumpTarget;
			default:     pcNext = aluResult;
		endcase
	end

	assign writeReg     = ctrl.regDst ? instr.rd : instr.rt;
	assign regWriteData = ctrl.memToReg ? mdr : aluOut;

	assign pcLoad = ctrl.pcWrite
		| (ctrl.pcWriteBeq & aluZero)
		| (ctrl.pcWriteBne & ~aluZero);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pc     <= iInitialPC;
			ir     <= '0;
			mdr    <= '0;
			regA   <= '0;
			regB   <= '0;
			aluOut <= '0;
		end
		else
		begin
			regA   <= readData1;   // reloaded every cycle, IR holds rs/rt
			regB   <= readData2;
			aluOut <= aluResult;
			if (ctrl.memRead)
				mdr <= DwReadData;  // same-cycle memory answer
			if (ctrl.irWrite)
				ir <= DwReadData;
			if (pcLoad)
				pc <= pcNext;
		end
	end

	multiCycleControl u_control (
		.iCLK   (iCLK),
		.iRST   (iRST),
		.opcode (instr.opcode),
		.ctrl   (ctrl),
		.state  (state)
	);

	registerFile u_regFile (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.readAddr1   (instr.rs),
		.readAddr2   (instr.rt),
		.writeAddr   (writeReg),
		.writeData   (regWriteData),
		.writeEnable (ctrl.regWrite),
		.readData1   (readData1),
		.readData2   (readData2)
	);

	aluUnit u_alu (
		.aluOp  (ctrl.aluOp),
		.funct  (instr.funct),
		.opA    (aluA),
		.opB    (aluB),
		.result (aluResult),
		.zero   (aluZero)
	);

	// memory bus, plain strobes
	assign DwAddress     = ctrl.iorD ? aluOut : pc;
	assign DwWriteData   = regB;
	assign DwReadEnable  = ctrl.memRead;
	assign DwWriteEnable = ctrl.memWrite;

	assign oPC    = pc;
	assign oState = state;

endmodule

`default_nettype wire

//--- tests/datapathMulti_sva.sv
// bound assertions on the memory bus strobes and the fetch address
// failures are counted for the testbench verdict
`timescale 1ns/1ps
`default_nettype none

module datapathMultiSva
	import mipsPkg::*;
(
	input logic       iCLK,
	input logic       iRST,
	input word_t      DwAddress,
	input logic       DwReadEnable,
	input logic       DwWriteEnable,
	input word_t      oPC,
	input ctrlState_t oState
);

	int failCount = 0;

	rwExclusive: assert property (@(posedge iCLK) disable iff (iRST)
		!(DwReadEnable && DwWriteEnable))
	else
	begin
		$error("read and write strobes high in the same cycle");
		failCount = failCount + 1;
	end

	// write strobe belongs to the sw memory state only
	writeOnlyInMemWrite: assert property (@(posedge iCLK) disable iff (iRST)
		DwWriteEnable |-> (oState == stMemWrite))
	else
	begin
		$error("write strobe outside stMemWrite");
		failCount = failCount + 1;
	end

	fetchAddrIsPc: assert property (@(posedge iCLK) disable iff (iRST)
		(oState == stFetch) |-> (DwAddress == oPC))
	else
	begin
		$error("fetch address differs from PC");
		failCount = failCount + 1;
	end

endmodule

bind datapathMulti datapathMultiSva u_sva (.*);

`default_nettype wire

//--- tests/isaModel.svh
// R, I and J instruction encoders
// instruction-level reference model filling the expected fetch, cycle and store queues
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

word_t refMem [int];   // keyed by word index
word_t refReg [32];
word_t expPc [$];      // fetch address of each executed instruction
int    expCycles [$];  // fetch to next fetch
word_t expStAddr [$];
word_t expStData [$];

function automatic word_t encR(input funct_t fn, input regAddr_t rs, input regAddr_t rt,
	input regAddr_t rd);
	return {opRType, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t encI(input opcode_t op, input regAddr_t rs, input regAddr_t rt,
	input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t encJ(input logic [25:0] target);
	return {opJ, target};  // word index of the target
endfunction

// runs until a jump to itself
task automatic runModel(input word_t startPc, input int stepCap);
	word_t        ins;
	word_t        pc;
	word_t        nextPc;
	word_t        a;
	word_t        b;
	word_t        imm;
	word_t        res;
	instrFields_t f;
	pc = startPc;
	foreach (refReg[i])
		refReg[i] = '0;
	for (int n = 0; n < stepCap; n++)
	begin
		ins = refMem[int'(pc[31:2])];
		f = instrFields_t'(ins);
		a = refReg[f.rs];
		b = refReg[f.rt];
		imm = {{16{ins[15]}}, ins[15:0]};  // sign extended
		nextPc = pc + 32'd4;
		expPc.push_back(pc);
		case (f.opcode)
			opRType:
			begin
				case (f.funct)
					fnSub:   res = a - b;
					fnAnd:   res = a & b;
					fnOr:    res = a | b;
					fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: res = a + b;
				endcase
				if (f.rd != '0)
					refReg[f.rd] = res;
				expCycles.push_back(4);
			end
			opAddi:
			begin
				if (f.rt != '0)
					refReg[f.rt] = a + imm;
				expCycles.push_back(4);
			end
			opLw:
			begin
				if (f.rt != '0)
					refReg[f.rt] = refMem[int'((a + imm) >> 2)];
				expCycles.push_back(5);
			end
			opSw:
			begin
				refMem[int'((a + imm) >> 2)] = b;
				expStAddr.push_back(a + imm);
				expStData.push_back(b);
				expCycles.push_back(4);
			end
			opBeq, opBne:
			begin
				if ((a == b) == (f.opcode == opBeq))  // taken
					nextPc = nextPc + (imm << 2);
				expCycles.push_back(3);
			end
			opJ:
			begin
				nextPc = {nextPc[31:28], ins[25:0], 2'b00};
				expCycles.push_back(3);
			end
			default: expCycles.push_back(2);  // unknown op, fetch and decode only
		endcase
		if (nextPc == pc)
			break;  // end of program
		pc = nextPc;
	end
endtask

`endif

//--- tests/datapathMultiTb.sv
// testbench for the multicycle core
// clock, reset, random program, word memory model
// fetch PC, cycle count, read strobe and store checks against the ISA model
`timescale 1ns/1ps
`default_nettype none

module datapathMultiTb
	import mipsPkg::*;
();

	localparam int memWords  = 2048;  // program low, data at 0x1000
	localparam int progLen   = 200;
	localparam int stepLimit = 16;    // cycles allowed per instruction

	logic       iCLK;
	logic       iRST;
	word_t      iInitialPC;
	word_t      DwReadData;
	word_t      DwAddress;
	word_t      DwWriteData;
	logic       DwReadEnable;
	logic       DwWriteEnable;
	word_t      oPC;
	ctrlState_t oState;

	word_t       mem [memWords];
	logic [31:0] rngState;
	int          storeIdx;
	int          cycles;
	logic        isLoad;   // current instruction is lw
	logic        expRead;  // read strobe expected this cycle

	`include "isaModel.svh"

	datapathMulti u_datapathMulti (.*);

	always #2 iCLK = ~iCLK;  // 4 ns

	// word memory, combinational read, write at the rising edge
	assign DwReadData = mem[DwAddress[12:2]];
	always @(posedge iCLK)
		if (DwWriteEnable)
			mem[DwAddress[12:2]] <= DwWriteData;

	always @(negedge iCLK)
		assert (u_datapathMulti.u_sva.failCount == 0)
			else reportFailure("bound bus assertion failed");

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic funct_t pickFunct(input logic [2:0] sel);
		case (sel)
			3'd0, 3'd5: return fnAdd;
			3'd1, 3'd6: return fnSub;
			3'd2:       return fnAnd;
			3'd3:       return fnOr;
			default:    return fnSlt;
		endcase
	endfunction

	task automatic buildProgram();
		logic [31:0] r;
		logic [15:0] dataOff;
		int          span;
		for (int a = 0; a < memWords; a++)
			mem[a] = (a * 32'h9e3779b1) ^ 32'h5ca1ab1e;  // hash of the word address
		for (int i = 0; i < progLen; i++)
		begin
			r = nextRand();
			span = int'(r[14:12]);
			if (i + 1 + span > progLen)
				span = progLen - i - 1;  // stay inside the program
			dataOff = 16'h1000 + {8'd0, r[25:20], 2'b00};
			case (r[31:28])
				4'd0, 4'd1, 4'd2, 4'd3:
					mem[i] = encR(pickFunct(r[11:9]), {2'b0, r[2:0]}, {2'b0, r[5:3]},
						{2'b0, r[8:6]});
				4'd4, 4'd5, 4'd6:
					mem[i] = encI(opAddi, {2'b0, r[2:0]}, {2'b0, r[5:3]}, r[27:12]);
				4'd7, 4'd8, 4'd9:
					mem[i] = encI(opLw, 5'd0, {2'b0, r[5:3]}, dataOff);
				4'd10, 4'd11:
					mem[i] = encI(opSw, 5'd0, {2'b0, r[5:3]}, dataOff);
				4'd12, 4'd13:
					mem[i] = encI(opBeq, {2'b0, r[2:0]}, {2'b0, r[5:3]}, 16'(span));
				4'd14:
					mem[i] = encI(opBne, {2'b0, r[2:0]}, {2'b0, r[5:3]}, 16'(span));
				default:
					mem[i] = encJ(26'(i + 1 + span));  // forward only
			endcase
		end
		mem[progLen] = encJ(26'(progLen));  // self loop ends the run
	endtask

	task automatic reportMismatch(input string name, input word_t got, input word_t want);
		$display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, want);
		$display("** FAIL **");
		$fatal(1, "mismatch");
	endtask

	task automatic reportFailure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	task automatic checkStore();
		assert (storeIdx < expStAddr.size())
			else reportFailure("write strobe with no store left in the model");
		assert (DwAddress == expStAddr[storeIdx])
			else reportMismatch("DwAddress", DwAddress, expStAddr[storeIdx]);
		assert (DwWriteData == expStData[storeIdx])
			else reportMismatch("DwWriteData", DwWriteData, expStData[storeIdx]);
		storeIdx++;
	endtask

	initial
	begin
		iCLK = 1'b0;
		iRST = 1'b1;
		iInitialPC = '0;
		rngState = 32'hf77b;
		storeIdx = 0;
		buildProgram();
		for (int a = 0; a < memWords; a++)
			refMem[a] = mem[a];
		runModel(iInitialPC, 4 * progLen);
		assert (expPc[$] == word_t'(progLen * 4))
			else reportFailure("model did not reach the final jump");
		repeat (16)
			@(negedge iCLK);
		assert (oState == stFetch)
			else reportFailure("state is not stFetch during reset");
		assert (oPC == iInitialPC)
			else reportMismatch("oPC", oPC, iInitialPC);
		assert (DwReadEnable)
			else reportFailure("read strobe low during reset");
		assert (!DwWriteEnable)
			else reportFailure("write strobe high during reset");
		iRST = 1'b0;
		for (int k = 0; k < expPc.size(); k++)
		begin
			assert (oPC == expPc[k])
				else reportMismatch("oPC", oPC, expPc[k]);
			if (k == expPc.size() - 1)
				break;  // sitting on the final self jump
			isLoad = (mem[expPc[k][12:2]][31:26] == opLw);
			cycles = 0;
			do
			begin
				@(negedge iCLK);
				cycles++;
				expRead = (cycles == expCycles[k]) || (isLoad && cycles == 3);  // fetch, lw read
				assert (DwReadEnable == expRead)
					else reportMismatch("DwReadEnable", DwReadEnable, expRead);
				if (DwWriteEnable)
					checkStore();
			end
			while (oState != stFetch && cycles < stepLimit);
			assert (oState == stFetch)
				else reportFailure("timeout waiting for the next fetch");
			assert (cycles == expCycles[k])
				else reportMismatch("fetch to fetch cycles", cycles, expCycles[k]);
		end
		assert (storeIdx == expStAddr.size())
			else reportFailure("not every expected store reached the bus");
		if (u_datapathMulti.u_sva.failCount == 0)
		begin
			$display("** PASS **");
			$finish;
		end
		else
			reportFailure("bound bus assertions reported errors");
	end

endmodule

`default_nettype wire

//--- datapathMulti.f
+incdir+tests
hw/mipsPkg.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/multiCycleControl.sv
hw/datapathMulti.sv
tests/datapathMulti_sva.sv
tests/datapathMultiTb.sv
